/* Bender.yml */
package:
  name: membus

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/membus_pkg.sv
      - verilog/membus_request_slice.sv
      - verilog/membus_slave_ctrl.sv
      - verilog/membus_sram.sv
      - verilog/membus_response_fifo.sv
      - verilog/membus_endpoint_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_membus_endpoint.sv

/* membus.f */
+incdir+verilog
verilog/membus_pkg.sv
verilog/membus_request_slice.sv
verilog/membus_slave_ctrl.sv
verilog/membus_sram.sv
verilog/membus_response_fifo.sv
verilog/membus_endpoint_top.sv
tb/tb_membus_endpoint.sv

/* tb/tb_membus_endpoint.sv */
/*
  Testbench for the memory bus endpoint.
  Directed tests against a reference memory model, checked with typed compare tasks.
*/
`include "membus_settings.svh"

module tb_membus_endpoint
  import membus_pkg::*;
();
  localparam int WAIT_LIMIT   = 200;
  localparam int MEM_DEPTH    = `MEMBUS_MEM_DEPTH;
  localparam int MIX_COMMANDS = 10;
  localparam int MIX_BASE     = 'h40;
  localparam int MIX_WORDS    = 16;

  logic                                       i_clk;
  logic                                       i_reset;
  logic                                       i_cmd_valid;
  logic                                       o_cmd_accept;
  logic [MEMBUS_PACKED_COMMAND_WIDTH-1:0]     i_cmd;
  logic                                       i_data_valid;
  logic                                       o_data_accept;
  logic [MEMBUS_PACKED_WRITE_DATA_WIDTH-1:0]  i_data;
  logic                                       o_resp_valid;
  logic                                       i_resp_accept;
  logic [MEMBUS_PACKED_RESPONSE_WIDTH-1:0]    o_resp;

  membus_data       ref_mem [MEM_DEPTH];
  membus_write_data burst [4];
  membus_command    mix_cmd [MIX_COMMANDS];
  membus_write_data mix_data [MIX_COMMANDS][4];
  membus_response   expected_queue [$];
  int               error_count;
  int               check_count;
  int               test_count;

  membus_endpoint_top UUT (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_cmd_valid    (i_cmd_valid),
    .o_cmd_accept   (o_cmd_accept),
    .i_cmd          (i_cmd),
    .i_data_valid   (i_data_valid),
    .o_data_accept  (o_data_accept),
    .i_data         (i_data),
    .o_resp_valid   (o_resp_valid),
    .i_resp_accept  (i_resp_accept),
    .o_resp         (o_resp)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  // Byte lanes with a set strobe bit take the new data.
  function automatic membus_data merge_bytes(membus_data old_word, membus_write_data beat);
    membus_data result;
    result = old_word;
    for (int i = 0; i < $bits(membus_strobe); i++) begin
      if (beat.strobe[i]) begin
        result[8*i+:8] = beat.data[8*i+:8];
      end
    end
    return result;
  endfunction

  function automatic logic out_of_range(membus_addr address, int beats);
    return (int'(address) + beats - 1) >= MEM_DEPTH; // Address plus length field.
  endfunction

  function automatic membus_command make_command(membus_command_kind cmd_kind, membus_id cmd_id,
                                                 membus_addr cmd_address, int beats);
    return '{kind: cmd_kind, id: cmd_id, address: cmd_address,
             length: membus_length'(beats - 1)};
  endfunction

  function automatic membus_response make_response(membus_response_kind resp_kind,
                                                   membus_id resp_id, membus_data resp_data,
                                                   logic resp_error, logic resp_last);
    return '{kind: resp_kind, id: resp_id, data: resp_data, error: resp_error, last: resp_last};
  endfunction

  task automatic compare_response(input string label, input membus_response actual,
                                  input membus_response expected);
    check_count++;
    if (actual.kind !== expected.kind) begin
      $display("FAIL %s o_resp.kind: got %h, expected %h", label, actual.kind, expected.kind);
      error_count++;
    end
    if (actual.id !== expected.id) begin
      $display("FAIL %s o_resp.id: got %h, expected %h", label, actual.id, expected.id);
      error_count++;
    end
    if (actual.data !== expected.data) begin
      $display("FAIL %s o_resp.data: got %h, expected %h", label, actual.data, expected.data);
      error_count++;
    end
    if (actual.error !== expected.error) begin
      $display("FAIL %s o_resp.error: got %h, expected %h", label, actual.error, expected.error);
      error_count++;
    end
    if (actual.last !== expected.last) begin
      $display("FAIL %s o_resp.last: got %h, expected %h", label, actual.last, expected.last);
      error_count++;
    end
  endtask

  task automatic compare_accept(input string label, input string signal, input logic actual,
                                input logic expected);
    check_count++;
    if (actual !== expected) begin
      $display("FAIL %s %s: got %h, expected %h", label, signal, actual, expected);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s did not happen within %0d cycles", what, WAIT_LIMIT);
    error_count++;
  endtask

  task automatic report_test(input string name, input int start_errors);
    test_count++;
    if (error_count == start_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - start_errors);
    end
  endtask

  task automatic send_command(input membus_command cmd);
    int waited;
    waited = 0;
    i_cmd = cmd;
    i_cmd_valid = 1'b1;
    @(negedge i_clk);
    while (!o_cmd_accept && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_cmd_accept) begin
      report_timeout("Command accept");
    end
    next_cycle();
    i_cmd_valid = 1'b0;
  endtask

  task automatic send_write_data(input membus_write_data beat);
    int waited;
    waited = 0;
    i_data = beat;
    i_data_valid = 1'b1;
    @(negedge i_clk);
    while (!o_data_accept && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_data_accept) begin
      report_timeout("Write data accept");
    end
    next_cycle();
    i_data_valid = 1'b0;
  endtask

  // Accept is raised only while a response is being collected.
  task automatic collect_response(output membus_response resp);
    int waited;
    waited = 0;
    i_resp_accept = 1'b1;
    @(negedge i_clk);
    while (!o_resp_valid && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_resp_valid) begin
      report_timeout("Response valid");
    end
    resp = membus_response'(o_resp);
    next_cycle();
    i_resp_accept = 1'b0;
  endtask

  task automatic randomize_burst(input logic full_strobes);
    for (int i = 0; i < 4; i++) begin
      burst[i].data   = $urandom;
      burst[i].strobe = full_strobes ? 4'hF : membus_strobe'($urandom);
    end
  endtask

  task automatic write_burst(input string label, input membus_id id, input membus_addr address,
                             input int beats);
    membus_response resp;
    logic           error;
    error = out_of_range(address, beats);
    send_command(make_command(MEMBUS_WRITE, id, address, beats));
    for (int i = 0; i < beats; i++) begin
      send_write_data(burst[i]);
      if (!error) begin
        ref_mem[int'(address) + i] = merge_bytes(ref_mem[int'(address) + i], burst[i]);
      end
    end
    collect_response(resp);
    compare_response(label, resp, make_response(MEMBUS_WRITE_ACK, id, '0, error, 1'b1));
  endtask

  task automatic read_burst(input string label, input membus_id id, input membus_addr address,
                            input int beats);
    membus_response resp;
    membus_data     data;
    logic           error;
    error = out_of_range(address, beats);
    send_command(make_command(MEMBUS_READ, id, address, beats));
    for (int i = 0; i < beats; i++) begin
      data = error ? '0 : ref_mem[int'(address) + i];
      collect_response(resp);
      compare_response(label, resp,
                       make_response(MEMBUS_READ_DATA, id, data, error, i == beats - 1));
    end
  endtask

  task automatic test_reset_state();
    int waited;
    int start_errors;
    start_errors = error_count;
    waited = 0;
    @(negedge i_clk);
    compare_accept("reset_state", "o_resp_valid", o_resp_valid, 1'b0);
    compare_accept("reset_state", "o_cmd_accept", o_cmd_accept, 1'b0);
    compare_accept("reset_state", "o_data_accept", o_data_accept, 1'b0);
    while (!(o_cmd_accept && o_data_accept) && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!(o_cmd_accept && o_data_accept)) begin
      report_timeout("Input accepts after reset");
    end
    next_cycle();
    report_test("reset_state", start_errors);
  endtask

  task automatic test_single_word();
    int start_errors;
    start_errors = error_count;
    burst[0] = '{data: 32'hA5C3_0F81, strobe: 4'hF};
    write_burst("single_word", 4'h3, 10'h010, 1);
    read_burst("single_word", 4'h4, 10'h010, 1);
    report_test("single_word", start_errors);
  endtask

  task automatic test_strobe_burst();
    int         start_errors;
    membus_addr address;
    start_errors = error_count;
    address = membus_addr'($urandom_range(MEM_DEPTH - 4));
    randomize_burst(1'b1); // Known contents first, so masked bytes are defined.
    write_burst("strobe_burst", 4'h5, address, 4);
    randomize_burst(1'b0);
    write_burst("strobe_burst", 4'h6, address, 4);
    read_burst("strobe_burst", 4'h7, address, 4);
    report_test("strobe_burst", start_errors);
  endtask

  task automatic test_range_errors();
    int start_errors;
    start_errors = error_count;
    randomize_burst(1'b1);
    write_burst("range_errors", 4'h8, 10'd252, 4);
    read_burst("range_errors", 4'h9, 10'd253, 4);
    read_burst("range_errors", 4'hD, 10'h100, 1);
    randomize_burst(1'b1);
    write_burst("range_errors", 4'hA, 10'd253, 4);
    write_burst("range_errors", 4'hB, 10'h3FC, 4); // Low bits alias words 252 to 255.
    read_burst("range_errors", 4'hC, 10'd252, 4);
    report_test("range_errors", start_errors);
  endtask

  task automatic test_backpressure_order();
    int                 start_errors;
    int                 beats;
    int                 address;
    membus_command_kind kind;
    membus_response     resp;
    start_errors = error_count;
    for (int b = 0; b < 4; b++) begin
      randomize_burst(1'b1);
      write_burst("backpressure_order", membus_id'(b), membus_addr'(MIX_BASE + 4 * b), 4);
    end
    for (int n = 0; n < MIX_COMMANDS; n++) begin
      beats   = $urandom_range(4, 1);
      address = MIX_BASE + $urandom_range(MIX_WORDS - beats);
      kind    = membus_command_kind'($urandom_range(1));
      mix_cmd[n] = make_command(kind, membus_id'(n), membus_addr'(address), beats);
      for (int i = 0; i < beats; i++) begin
        if (kind == MEMBUS_WRITE) begin
          mix_data[n][i].data   = $urandom;
          mix_data[n][i].strobe = membus_strobe'($urandom);
          ref_mem[address + i]  = merge_bytes(ref_mem[address + i], mix_data[n][i]);
        end else begin
          expected_queue.push_back(make_response(MEMBUS_READ_DATA, membus_id'(n),
                                                 ref_mem[address + i], 1'b0, i == beats - 1));
        end
      end
      if (kind == MEMBUS_WRITE) begin
        expected_queue.push_back(make_response(MEMBUS_WRITE_ACK, membus_id'(n), '0, 1'b0, 1'b1));
      end
    end
    fork
      begin
        for (int n = 0; n < MIX_COMMANDS; n++) begin
          send_command(mix_cmd[n]);
          if (mix_cmd[n].kind == MEMBUS_WRITE) begin
            for (int i = 0; i <= int'(mix_cmd[n].length); i++) begin
              send_write_data(mix_data[n][i]);
            end
          end
        end
      end
      begin
        while (expected_queue.size() > 0) begin
          repeat ($urandom_range(4)) next_cycle(); // Accept held low for a while.
          collect_response(resp);
          compare_response("backpressure_order", resp, expected_queue.pop_front());
        end
      end
    join
    repeat (8) next_cycle();
    @(negedge i_clk);
    compare_accept("backpressure_order", "o_resp_valid", o_resp_valid, 1'b0);
    next_cycle();
    report_test("backpressure_order", start_errors);
  endtask

  initial begin
    error_count   = 0;
    check_count   = 0;
    test_count    = 0;
    i_reset       = 1'b1;
    i_cmd_valid   = 1'b0;
    i_cmd         = '0;
    i_data_valid  = 1'b0;
    i_data        = '0;
    i_resp_accept = 1'b0;
    void'($urandom(86));
    repeat (5) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    test_reset_state();
    test_single_word();
    test_strobe_burst();
    test_range_errors();
    test_backpressure_order();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end
endmodule

/* verilog/membus_endpoint_top.sv */
/*
  Memory bus endpoint.
  Request slice, burst controller, SRAM and response queue.
*/
module membus_endpoint_top
  import membus_pkg::*;
(
  input   var logic                                       i_clk,
  input   var logic                                       i_reset,
  input   var logic                                       i_cmd_valid,
  output  var logic                                       o_cmd_accept,
  input   var logic [MEMBUS_PACKED_COMMAND_WIDTH-1:0]     i_cmd,
  input   var logic                                       i_data_valid,
  output  var logic                                       o_data_accept,
  input   var logic [MEMBUS_PACKED_WRITE_DATA_WIDTH-1:0]  i_data,
  output  var logic                                       o_resp_valid,
  input   var logic                                       i_resp_accept,
  output  var logic [MEMBUS_PACKED_RESPONSE_WIDTH-1:0]    o_resp
);
  logic             cmd_valid;
  logic             cmd_accept;
  membus_command    command;
  logic             data_valid;
  logic             data_accept;
  membus_write_data write_data;
  logic             mem_write;
  logic             mem_read;
  membus_addr       mem_address;
  membus_data       mem_write_data;
  membus_strobe     mem_strobe;
  membus_data       mem_read_data;
  logic             resp_push;
  membus_response   response;
  logic             can_push;

  membus_request_slice u_request_slice (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_cmd_valid    (i_cmd_valid),
    .o_cmd_accept   (o_cmd_accept),
    .i_cmd          (i_cmd),
    .i_data_valid   (i_data_valid),
    .o_data_accept  (o_data_accept),
    .i_data         (i_data),
    .o_cmd_valid    (cmd_valid),
    .i_cmd_accept   (cmd_accept),
    .o_command      (command),
    .o_data_valid   (data_valid),
    .i_data_accept  (data_accept),
    .o_write_data   (write_data)
  );

  membus_slave_ctrl u_slave_ctrl (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_cmd_valid      (cmd_valid),
    .o_cmd_accept     (cmd_accept),
    .i_command        (command),
    .i_data_valid     (data_valid),
    .o_data_accept    (data_accept),
    .i_write_data     (write_data),
    .o_mem_write      (mem_write),
    .o_mem_read       (mem_read),
    .o_mem_address    (mem_address),
    .o_mem_write_data (mem_write_data),
    .o_mem_strobe     (mem_strobe),
    .i_mem_read_data  (mem_read_data),
    .o_resp_push      (resp_push),
    .o_response       (response),
    .i_can_push       (can_push)
  );

  membus_sram u_sram (
    .i_clk        (i_clk),
    .i_write      (mem_write),
    .i_read       (mem_read),
    .i_address    (mem_address),
    .i_write_data (mem_write_data),
    .i_strobe     (mem_strobe),
    .o_read_data  (mem_read_data)
  );

  membus_response_fifo u_response_fifo (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_push         (resp_push),
    .i_response     (response),
    .o_can_push     (can_push),
    .o_resp_valid   (o_resp_valid),
    .i_resp_accept  (i_resp_accept),
    .o_resp         (o_resp)
  );
endmodule

/* verilog/membus_pkg.sv */
/*
  Memory bus types.
  Field vectors, command and response kinds, the three channel structs
  and the controller state encoding.
*/
`include "membus_settings.svh"

package membus_pkg;
  typedef logic [`MEMBUS_ADDR_WIDTH-1:0]     membus_addr;
  typedef logic [`MEMBUS_DATA_WIDTH-1:0]     membus_data;
  typedef logic [`MEMBUS_ID_WIDTH-1:0]       membus_id;
  typedef logic [`MEMBUS_LENGTH_WIDTH-1:0]   membus_length;
  typedef logic [`MEMBUS_DATA_WIDTH/8-1:0]   membus_strobe;

  typedef enum logic {
    MEMBUS_READ  = 1'b0,
    MEMBUS_WRITE = 1'b1
  } membus_command_kind;

  typedef enum logic {
    MEMBUS_READ_DATA = 1'b0,
    MEMBUS_WRITE_ACK = 1'b1
  } membus_response_kind;

  typedef struct packed {
    membus_command_kind kind;
    membus_id           id;
    membus_addr         address;
    membus_length       length;
  } membus_command;

  typedef struct packed {
    membus_data   data;
    membus_strobe strobe;
  } membus_write_data;

  typedef struct packed {
    membus_response_kind  kind;
    membus_id             id;
    membus_data           data;
    logic                 error;
    logic                 last;
  } membus_response;

  localparam int MEMBUS_PACKED_COMMAND_WIDTH    = $bits(membus_command);
  localparam int MEMBUS_PACKED_WRITE_DATA_WIDTH = $bits(membus_write_data);
  localparam int MEMBUS_PACKED_RESPONSE_WIDTH   = $bits(membus_response);

  typedef enum logic [1:0] {
    MEMBUS_CTRL_IDLE,
    MEMBUS_CTRL_WRITE_BURST,
    MEMBUS_CTRL_READ_BURST,
    MEMBUS_CTRL_WRITE_RESPOND
  } membus_ctrl_state;
endpackage

/* verilog/membus_request_slice.sv */
/*
  Request slice.
  Takes packed command and write data beats, unpacks them into structs
  and holds one registered entry per channel.
*/
module membus_request_slice
  import membus_pkg::*;
(
  input   var logic                                       i_clk,
  input   var logic                                       i_reset,
  input   var logic                                       i_cmd_valid,
  output  var logic                                       o_cmd_accept,
  input   var logic [MEMBUS_PACKED_COMMAND_WIDTH-1:0]     i_cmd,
  input   var logic                                       i_data_valid,
  output  var logic                                       o_data_accept,
  input   var logic [MEMBUS_PACKED_WRITE_DATA_WIDTH-1:0]  i_data,
  output  var logic                                       o_cmd_valid,
  input   var logic                                       i_cmd_accept,
  output  var membus_command                              o_command,
  output  var logic                                       o_data_valid,
  input   var logic                                       i_data_accept,
  output  var membus_write_data                           o_write_data
);
  logic             running;
  logic             cmd_valid;
  logic             cmd_take;
  membus_command    command_q;
  logic             data_valid;
  logic             data_take;
  membus_write_data write_data_q;

  // Inputs stay closed until the first cycle after reset.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  always_comb begin
    o_cmd_accept  = running && (!cmd_valid || i_cmd_accept); // Free or draining this cycle.
    o_data_accept = running && (!data_valid || i_data_accept);
    cmd_take      = i_cmd_valid && o_cmd_accept;
    data_take     = i_data_valid && o_data_accept;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cmd_valid   <= 1'b0;
      data_valid  <= 1'b0;
    end else begin
      if (cmd_take) begin
        cmd_valid <= 1'b1;
      end else if (i_cmd_accept) begin
        cmd_valid <= 1'b0;
      end
      if (data_take) begin
        data_valid <= 1'b1;
      end else if (i_data_accept) begin
        data_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_take) begin
      command_q <= membus_command'(i_cmd);
    end
    if (data_take) begin
      write_data_q <= membus_write_data'(i_data);
    end
  end

  always_comb begin
    o_cmd_valid   = cmd_valid;
    o_command     = command_q;
    o_data_valid  = data_valid;
    o_write_data  = write_data_q;
  end
endmodule

/* verilog/membus_response_fifo.sv */
/*
  Response queue.
  Holds response structs and presents the head as a packed vector on
  the response channel.
*/
`include "membus_settings.svh"

module membus_response_fifo
  import membus_pkg::*;
(
  input   var logic                                     i_clk,
  input   var logic                                     i_reset,
  input   var logic                                     i_push,
  input   var membus_response                           i_response,
  output  var logic                                     o_can_push,
  output  var logic                                     o_resp_valid,
  input   var logic                                     i_resp_accept,
  output  var logic [MEMBUS_PACKED_RESPONSE_WIDTH-1:0]  o_resp
);
  localparam int DEPTH       = `MEMBUS_RESP_FIFO_DEPTH;
  localparam int PTR_WIDTH   = $clog2(DEPTH);
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  membus_response         entries [DEPTH];
  logic [PTR_WIDTH-1:0]   write_ptr;
  logic [PTR_WIDTH-1:0]   read_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   pop;

  always_comb begin
    o_resp_valid  = count != '0;
    o_resp        = entries[read_ptr];
    pop           = o_resp_valid && i_resp_accept;
    o_can_push    = count <= COUNT_WIDTH'(DEPTH - 2); // One slot kept for a read in flight.
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (i_push) begin
        write_ptr <= (write_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
      end
      if (pop) begin
        read_ptr <= (read_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
      end
      if (i_push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !i_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      entries[write_ptr] <= i_response;
    end
  end
endmodule

/* verilog/membus_settings.svh */
/*
  Memory bus endpoint settings.
  Bus field widths, SRAM depth and response queue depth.
*/
`ifndef MEMBUS_SETTINGS_SVH
`define MEMBUS_SETTINGS_SVH

// Word address, wider than the SRAM so that out of range commands can be seen.
`define MEMBUS_ADDR_WIDTH 10

`define MEMBUS_DATA_WIDTH 32

`define MEMBUS_ID_WIDTH 4

// Beats minus one, so 1 to 4 beats.
`define MEMBUS_LENGTH_WIDTH 2

`define MEMBUS_MEM_DEPTH 256

`define MEMBUS_RESP_FIFO_DEPTH 4

`endif

/* verilog/membus_slave_ctrl.sv */
/*
  Burst controller.
  Checks the command range, runs read and write bursts against the SRAM
  and builds read_data and write_ack responses.
*/
`include "membus_settings.svh"

module membus_slave_ctrl
  import membus_pkg::*;
(
  input   var logic             i_clk,
  input   var logic             i_reset,
  input   var logic             i_cmd_valid,
  output  var logic             o_cmd_accept,
  input   var membus_command    i_command,
  input   var logic             i_data_valid,
  output  var logic             o_data_accept,
  input   var membus_write_data i_write_data,
  output  var logic             o_mem_write,
  output  var logic             o_mem_read,
  output  var membus_addr       o_mem_address,
  output  var membus_data       o_mem_write_data,
  output  var membus_strobe     o_mem_strobe,
  input   var membus_data       i_mem_read_data,
  output  var logic             o_resp_push,
  output  var membus_response   o_response,
  input   var logic             i_can_push
);
  localparam int END_WIDTH = `MEMBUS_ADDR_WIDTH + 1;

  membus_ctrl_state       state;
  membus_id               id_q;
  membus_addr             address_q;
  membus_length           beats_q;      // Remaining beats minus one.
  logic                   error_q;
  logic                   read_pending;
  logic                   read_last;
  logic                   take_command;
  logic                   data_beat;
  logic                   read_beat;
  logic                   range_error;
  logic [END_WIDTH-1:0]   end_address;

  always_comb begin
    end_address   = {1'b0, i_command.address} + END_WIDTH'(i_command.length); // Last word.
    range_error   = end_address >= END_WIDTH'(`MEMBUS_MEM_DEPTH);
    o_cmd_accept  = state == MEMBUS_CTRL_IDLE;
    o_data_accept = state == MEMBUS_CTRL_WRITE_BURST;
    take_command  = i_cmd_valid && o_cmd_accept;
    data_beat     = i_data_valid && o_data_accept;
    read_beat     = (state == MEMBUS_CTRL_READ_BURST) && i_can_push;
  end

  always_comb begin
    o_mem_write       = data_beat && !error_q;  // Error bursts never touch the SRAM.
    o_mem_read        = read_beat && !error_q;
    o_mem_address     = address_q;
    o_mem_write_data  = i_write_data.data;
    o_mem_strobe      = i_write_data.strobe;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state         <= MEMBUS_CTRL_IDLE;
      read_pending  <= 1'b0;
    end else begin
      read_pending <= read_beat;
      case (state)
        MEMBUS_CTRL_IDLE: begin
          if (take_command && (i_command.kind == MEMBUS_WRITE)) begin
            state <= MEMBUS_CTRL_WRITE_BURST;
          end else if (take_command) begin
            state <= MEMBUS_CTRL_READ_BURST;
          end
        end
        MEMBUS_CTRL_WRITE_BURST: begin
          if (data_beat && (beats_q == '0)) begin
            state <= MEMBUS_CTRL_WRITE_RESPOND;
          end
        end
        MEMBUS_CTRL_READ_BURST: begin
          if (read_beat && (beats_q == '0)) begin
            state <= MEMBUS_CTRL_IDLE;
          end
        end
        default: begin
          if (i_can_push) begin // The ack waits for room in the queue.
            state <= MEMBUS_CTRL_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (take_command) begin
      id_q      <= i_command.id;
      address_q <= i_command.address;
      beats_q   <= i_command.length;
      error_q   <= range_error;
    end else if (data_beat || read_beat) begin
      address_q <= membus_addr'(address_q + 1'b1);
      beats_q   <= beats_q - 1'b1;
    end
    if (read_beat) begin
      read_last <= beats_q == '0;
    end
  end

  // Read data returns one cycle after the read, so the push follows it.
  always_comb begin
    o_resp_push       = read_pending || ((state == MEMBUS_CTRL_WRITE_RESPOND) && i_can_push);
    o_response.id     = id_q;
    o_response.error  = error_q;
    if (read_pending) begin
      o_response.kind = MEMBUS_READ_DATA;
      o_response.data = error_q ? '0 : i_mem_read_data;
      o_response.last = read_last;
    end else begin
      o_response.kind = MEMBUS_WRITE_ACK;
      o_response.data = '0;
      o_response.last = 1'b1;
    end
  end
endmodule

/* verilog/membus_sram.sv */
/*
  Word SRAM with byte enables.
  Single port, read data registered one cycle after the read strobe.
*/
`include "membus_settings.svh"

module membus_sram
  import membus_pkg::*;
(
  input   var logic         i_clk,
  input   var logic         i_write,
  input   var logic         i_read,
  input   var membus_addr   i_address,
  input   var membus_data   i_write_data,
  input   var membus_strobe i_strobe,
  output  var membus_data   o_read_data
);
  localparam int INDEX_WIDTH = $clog2(`MEMBUS_MEM_DEPTH);
  localparam int BYTES       = $bits(membus_strobe);

  membus_data             mem [`MEMBUS_MEM_DEPTH];
  logic [INDEX_WIDTH-1:0] index;

  always_comb begin
    index = i_address[INDEX_WIDTH-1:0];
  end

  always_ff @(posedge i_clk) begin
    if (i_write) begin
      for (int i = 0; i < BYTES; i++) begin
        if (i_strobe[i]) begin
          mem[index][8*i+:8] <= i_write_data[8*i+:8];
        end
      end
    end
    if (i_read) begin
      o_read_data <= mem[index];
    end
  end
endmodule
